//--- rtl/pmp_checker.sv
`timescale 1ns/10ps

module pmp_checker (
  input  logic clock,
  input  logic reset,
  input  logic awvalid,
  output logic awready,
  input  logic [pmp_pkg::axi_addr_width-1:0] awaddr,
  input  logic wvalid,
  output logic wready,
  input  logic [31:0] wdata,
  input  logic [3:0] wstrb,
  output logic bvalid,
  input  logic bready,
  output logic [1:0] bresp,
  input  logic arvalid,
  output logic arready,
  input  logic [pmp_pkg::axi_addr_width-1:0] araddr,
  output logic rvalid,
  input  logic rready,
  output logic [31:0] rdata,
  output logic [1:0] rresp,
  input  logic access_valid,
  input  logic [31:0] access_addr,
  input  logic access_instr,
  input  logic access_write,
  input  logic access_machine,
  output logic result_valid,
  output logic access_fault
);

  pmp_pkg::pmp_cfg_word_t cfg_words [pmp_pkg::cfg_word_count];
  logic [31:0] pmp_addrs [pmp_pkg::region_count];
  logic [pmp_pkg::region_count-1:0] region_match;
  logic [pmp_pkg::region_count-1:0] region_allow;

  pmp_csr_axil pmp_csr_axil_inst (
    .clock     (clock),
    .reset     (reset),
    .awvalid   (awvalid),
    .awready   (awready),
    .awaddr    (awaddr),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .rresp     (rresp),
    .cfg_words (cfg_words),
    .pmp_addrs (pmp_addrs)
  );

  // Region 0 uses zero as its TOR lower bound
  for (genvar i = 0; i < pmp_pkg::region_count; i++) begin : gen_region
    pmp_region_match #(
      .first_region (i == 0)
    ) pmp_region_match_inst (
      .cfg_entry      (cfg_words[i / 4].entry[i % 4]),
      .addr_this      (pmp_addrs[i]),
      .addr_prev      (pmp_addrs[(i == 0) ? 0 : i - 1]),
      .access_addr    (access_addr),
      .access_instr   (access_instr),
      .access_write   (access_write),
      .access_machine (access_machine),
      .match          (region_match[i]),
      .allow          (region_allow[i])
    );
  end

  pmp_priority_resolve pmp_priority_resolve_inst (
    .clock          (clock),
    .reset          (reset),
    .access_valid   (access_valid),
    .access_machine (access_machine),
    .match          (region_match),
    .allow          (region_allow),
    .result_valid   (result_valid),
    .access_fault   (access_fault)
  );

endmodule

//--- rtl/pmp_csr_axil.sv
`timescale 1ns/10ps

module pmp_csr_axil (
  input  logic clock,
  input  logic reset,
  input  logic awvalid,
  output logic awready,
  input  logic [pmp_pkg::axi_addr_width-1:0] awaddr,
  input  logic wvalid,
  output logic wready,
  input  logic [31:0] wdata,
  input  logic [3:0] wstrb,
  output logic bvalid,
  input  logic bready,
  output logic [1:0] bresp,
  input  logic arvalid,
  output logic arready,
  input  logic [pmp_pkg::axi_addr_width-1:0] araddr,
  output logic rvalid,
  input  logic rready,
  output logic [31:0] rdata,
  output logic [1:0] rresp,
  output pmp_pkg::pmp_cfg_word_t cfg_words [pmp_pkg::cfg_word_count],
  output logic [31:0] pmp_addrs [pmp_pkg::region_count]
);

  logic write_fire;
  logic read_fire;
  logic [1:0] write_resp;
  logic [31:0] read_data;
  logic [1:0] read_resp;
  logic [pmp_pkg::region_count-1:0] addr_locked;

  function automatic logic cfg_hit(input logic [pmp_pkg::axi_addr_width-1:0] addr);
    return (int'(addr) >= int'(pmp_pkg::cfg_base)) &&
           (int'(addr) < int'(pmp_pkg::cfg_base) + 4 * pmp_pkg::cfg_word_count);
  endfunction

  function automatic logic addr_hit(input logic [pmp_pkg::axi_addr_width-1:0] addr);
    return (int'(addr) >= int'(pmp_pkg::addr_base)) &&
           (int'(addr) < int'(pmp_pkg::addr_base) + 4 * pmp_pkg::region_count);
  endfunction

  function automatic logic [pmp_pkg::cfg_index_width-1:0] cfg_index(
    input logic [pmp_pkg::axi_addr_width-1:0] addr
  );
    logic [pmp_pkg::axi_addr_width-1:0] offset;
    offset = addr - pmp_pkg::cfg_base;
    return offset[2 +: pmp_pkg::cfg_index_width];
  endfunction

  function automatic logic [pmp_pkg::region_index_width-1:0] addr_index(
    input logic [pmp_pkg::axi_addr_width-1:0] addr
  );
    logic [pmp_pkg::axi_addr_width-1:0] offset;
    offset = addr - pmp_pkg::addr_base;
    return offset[2 +: pmp_pkg::region_index_width];
  endfunction

  // Reserved bits never stored
  function automatic pmp_pkg::pmp_cfg_entry_t clean_entry(input logic [7:0] value);
    pmp_pkg::pmp_cfg_entry_t entry;
    entry = value;
    entry.reserved = 2'b00;
    return entry;
  endfunction

  // Address and data taken together
  assign write_fire = awvalid && wvalid && !bvalid;
  assign awready = write_fire;
  assign wready = write_fire;

  assign arready = !rvalid;
  assign read_fire = arvalid && arready;

  assign write_resp = (cfg_hit(awaddr) || addr_hit(awaddr)) ?
                      pmp_pkg::resp_okay : pmp_pkg::resp_slverr;

  // pmpaddr i is frozen by its own lock or by a locked TOR entry above it
  always_comb begin
    for (int i = 0; i < pmp_pkg::region_count; i++) begin
      addr_locked[i] = cfg_words[i / 4].entry[i % 4].lock;
    end
    for (int i = 0; i < pmp_pkg::region_count - 1; i++) begin
      if (cfg_words[(i + 1) / 4].entry[(i + 1) % 4].lock &&
          cfg_words[(i + 1) / 4].entry[(i + 1) % 4].mode == pmp_pkg::mode_tor) begin
        addr_locked[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int n = 0; n < pmp_pkg::cfg_word_count; n++) begin
        cfg_words[n] <= '0;
      end
      for (int i = 0; i < pmp_pkg::region_count; i++) begin
        pmp_addrs[i] <= '0;
      end
    end else if (write_fire) begin
      if (cfg_hit(awaddr)) begin
        for (int k = 0; k < 4; k++) begin
          if (wstrb[k] && !cfg_words[cfg_index(awaddr)].entry[k].lock) begin
            cfg_words[cfg_index(awaddr)].entry[k] <= clean_entry(wdata[8*k +: 8]);
          end
        end
      end
      if (addr_hit(awaddr) && !addr_locked[addr_index(awaddr)]) begin
        for (int k = 0; k < 4; k++) begin
          if (wstrb[k]) begin
            pmp_addrs[addr_index(awaddr)][8*k +: 8] <= wdata[8*k +: 8];
          end
        end
      end
    end
  end

  // Write response channel
  always_ff @(posedge clock) begin
    if (reset) begin
      bvalid <= 1'b0;
    end else if (write_fire) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (write_fire) begin
      bresp <= write_resp;
    end
  end

  always_comb begin
    read_data = '0;
    read_resp = pmp_pkg::resp_slverr;
    if (cfg_hit(araddr)) begin
      read_data = cfg_words[cfg_index(araddr)].raw;
      read_resp = pmp_pkg::resp_okay;
    end else if (addr_hit(araddr)) begin
      read_data = pmp_addrs[addr_index(araddr)];
      read_resp = pmp_pkg::resp_okay;
    end
  end

  // Read data held stable until rready
  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (read_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (read_fire) begin
      rdata <= read_data;
      rresp <= read_resp;
    end
  end

endmodule

//--- rtl/pmp_pkg.sv
package pmp_pkg;

  // Region count must stay a multiple of 4
  localparam int region_count = 16;
  localparam int cfg_word_count = region_count / 4;
  localparam int region_index_width = $clog2(region_count);
  localparam int cfg_index_width = $clog2(cfg_word_count);

  // Address matching modes
  localparam logic [1:0] mode_off = 2'd0;
  localparam logic [1:0] mode_tor = 2'd1;
  localparam logic [1:0] mode_na4 = 2'd2;
  localparam logic [1:0] mode_napot = 2'd3;

  // AXI4-Lite register map
  localparam int axi_addr_width = 8;
  localparam logic [axi_addr_width-1:0] cfg_base = 8'h00;
  localparam logic [axi_addr_width-1:0] addr_base = 8'h40;

  localparam logic [1:0] resp_okay = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // One pmpcfg entry, read in bit 0
  typedef struct packed {
    logic lock;
    logic [1:0] reserved;
    logic [1:0] mode;
    logic execute;
    logic write;
    logic read;
  } pmp_cfg_entry_t;

  // Bus word or four entries, entry k in byte k
  typedef union packed {
    logic [31:0] raw;
    pmp_cfg_entry_t [3:0] entry;
  } pmp_cfg_word_t;

endpackage

//--- rtl/pmp_priority_resolve.sv
`timescale 1ns/10ps

module pmp_priority_resolve (
  input  logic clock,
  input  logic reset,
  input  logic access_valid,
  input  logic access_machine,
  input  logic [pmp_pkg::region_count-1:0] match,
  input  logic [pmp_pkg::region_count-1:0] allow,
  output logic result_valid,
  output logic access_fault
);

  logic found;
  logic fault_next;

  // Lowest matching index decides
  always_comb begin
    found = 1'b0;
    fault_next = !access_machine;
    for (int i = 0; i < pmp_pkg::region_count; i++) begin
      if (!found && match[i]) begin
        found = 1'b1;
        fault_next = !allow[i];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result_valid <= 1'b0;
      access_fault <= 1'b0;
    end else begin
      result_valid <= access_valid;
      access_fault <= access_valid && fault_next;
    end
  end

endmodule

//--- rtl/pmp_region_match.sv
`timescale 1ns/10ps

module pmp_region_match #(
  parameter bit first_region = 1'b0
) (
  input  pmp_pkg::pmp_cfg_entry_t cfg_entry,
  input  logic [31:0] addr_this,
  input  logic [31:0] addr_prev,
  input  logic [31:0] access_addr,
  input  logic access_instr,
  input  logic access_write,
  input  logic access_machine,
  output logic match,
  output logic allow
);

  logic [29:0] word;
  logic [29:0] upper;
  logic [29:0] lower;
  logic [29:0] napot_span;
  logic [29:0] napot_diff;
  logic permission;

  // Compare in word units
  assign word = access_addr[31:2];
  assign upper = addr_this[29:0];
  assign lower = first_region ? 30'd0 : addr_prev[29:0];

  // Trailing ones plus the lowest zero mark the don't-care bits
  assign napot_span = upper ^ (upper + 30'd1);
  assign napot_diff = (word ^ upper) & ~napot_span;

  always_comb begin
    case (cfg_entry.mode)
      pmp_pkg::mode_off: begin
        match = 1'b0;
      end
      pmp_pkg::mode_tor: begin
        match = (word >= lower) && (word < upper);
      end
      pmp_pkg::mode_na4: begin
        match = (word == upper);
      end
      pmp_pkg::mode_napot: begin
        match = (napot_diff == 30'd0);
      end
      default: begin
        match = 1'b0;
      end
    endcase
  end

  always_comb begin
    if (access_instr) begin
      permission = cfg_entry.execute;
    end else if (access_write) begin
      permission = cfg_entry.write;
    end else begin
      permission = cfg_entry.read;
    end
  end

  // Locked entries bind machine mode too
  assign allow = permission || (access_machine && !cfg_entry.lock);

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f verilog.f --top-module pmp_checker_tb -o pmp_checker_sim \
  && ./obj_dir/pmp_checker_sim \
  || exit 1

//--- tb/pmp_checker_tb.sv
`timescale 1ns/10ps

module pmp_checker_tb;

  localparam int wait_limit = 32;

  logic clock = 1'b0;
  logic reset;
  logic awvalid;
  logic awready;
  logic [pmp_pkg::axi_addr_width-1:0] awaddr;
  logic wvalid;
  logic wready;
  logic [31:0] wdata;
  logic [3:0] wstrb;
  logic bvalid;
  logic bready;
  logic [1:0] bresp;
  logic arvalid;
  logic arready;
  logic [pmp_pkg::axi_addr_width-1:0] araddr;
  logic rvalid;
  logic rready;
  logic [31:0] rdata;
  logic [1:0] rresp;
  logic access_valid;
  logic [31:0] access_addr;
  logic access_instr;
  logic access_write;
  logic access_machine;
  logic result_valid;
  logic access_fault;

  string test_name;
  // Shadow registers with lock in bit 7 and mode in bits 4:3
  logic [7:0] cfg_model [pmp_pkg::region_count];
  logic [31:0] addr_model [pmp_pkg::region_count];

  pmp_checker pmp_checker_inst (.*);

  always #50 clock = ~clock;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("ERR %s %s: expected %h, actual %h",
                          test_name, what, expected, actual));
    end
  endtask

  task automatic tick_wait(inout int waited, input string what);
    waited++;
    if (waited > wait_limit) begin
      abort_run($sformatf("Timed out in %s waiting for %s", test_name, what));
    end
    @(negedge clock);
    #1;
  endtask

  function automatic logic [1:0] model_resp(input logic [7:0] addr);
    if (addr < 8'h10 || (addr >= 8'h40 && addr < 8'h80)) begin
      return pmp_pkg::resp_okay;
    end
    return pmp_pkg::resp_slverr;
  endfunction

  task automatic model_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    int idx;
    logic frozen;
    idx = int'(addr[7:2]);
    if (addr < 8'h10) begin
      for (int k = 0; k < 4; k++) begin
        if (strb[k] && !cfg_model[4 * idx + k][7]) begin
          cfg_model[4 * idx + k] = data[8 * k +: 8] & 8'h9F;
        end
      end
    end else if (addr >= 8'h40 && addr < 8'h80) begin
      idx = idx - 16;
      frozen = cfg_model[idx][7];
      // Locked TOR entry above also freezes this address
      if (idx < pmp_pkg::region_count - 1) begin
        if (cfg_model[idx + 1][7] && cfg_model[idx + 1][4:3] == pmp_pkg::mode_tor) begin
          frozen = 1'b1;
        end
      end
      for (int k = 0; k < 4; k++) begin
        if (strb[k] && !frozen) begin
          addr_model[idx][8 * k +: 8] = data[8 * k +: 8];
        end
      end
    end
  endtask

  function automatic logic model_match(input int i, input logic [31:0] addr);
    logic [29:0] word;
    logic [29:0] top;
    logic [29:0] base;
    int zero_bit;
    word = addr[31:2];
    top = addr_model[i][29:0];
    if (i == 0) begin
      base = 30'd0;
    end else begin
      base = addr_model[i - 1][29:0];
    end
    zero_bit = 30;
    for (int b = 29; b >= 0; b--) begin
      if (!top[b]) begin
        zero_bit = b;
      end
    end
    case (cfg_model[i][4:3])
      pmp_pkg::mode_tor: return (word >= base) && (word < top);
      pmp_pkg::mode_na4: return word == top;
      pmp_pkg::mode_napot: return (word >> (zero_bit + 1)) == (top >> (zero_bit + 1));
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic model_fault(input logic [31:0] addr, input logic instr,
                                       input logic write, input logic machine);
    logic found;
    logic fault;
    logic perm;
    found = 1'b0;
    fault = !machine;
    for (int i = 0; i < pmp_pkg::region_count; i++) begin
      if (!found && model_match(i, addr)) begin
        found = 1'b1;
        perm = instr ? cfg_model[i][2] : (write ? cfg_model[i][1] : cfg_model[i][0]);
        fault = !(perm || (machine && !cfg_model[i][7]));
      end
    end
    return fault;
  endfunction

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int waited;
    @(negedge clock);
    awvalid = 1'b1;
    wvalid = 1'b1;
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    #1;
    waited = 0;
    while (!(awready && wready)) tick_wait(waited, "awready and wready");
    @(negedge clock);
    awvalid = 1'b0;
    wvalid = 1'b0;
    waited = 0;
    while (!bvalid) tick_wait(waited, "bvalid");
    check_value($sformatf("bresp @%h", addr), 32'(model_resp(addr)), 32'(bresp));
    bready = 1'b1;
    @(negedge clock);
    bready = 1'b0;
    model_write(addr, data, strb);
  endtask

  task automatic axi_read_check(input logic [7:0] addr, input logic [31:0] exp_data,
                                input logic [1:0] exp_resp);
    int waited;
    @(negedge clock);
    arvalid = 1'b1;
    araddr = addr;
    #1;
    waited = 0;
    while (!arready) tick_wait(waited, "arready");
    @(negedge clock);
    arvalid = 1'b0;
    waited = 0;
    while (!rvalid) tick_wait(waited, "rvalid");
    check_value($sformatf("rdata @%h", addr), exp_data, rdata);
    check_value($sformatf("rresp @%h", addr), 32'(exp_resp), 32'(rresp));
    rready = 1'b1;
    @(negedge clock);
    rready = 1'b0;
  endtask

  // Result is due exactly one cycle after the access
  task automatic check_access(input logic [31:0] addr, input logic instr,
                              input logic write, input logic machine);
    logic expected;
    @(negedge clock);
    check_value("idle result_valid", 32'd0, 32'(result_valid));
    check_value("idle access_fault", 32'd0, 32'(access_fault));
    access_valid = 1'b1;
    access_addr = addr;
    access_instr = instr;
    access_write = write;
    access_machine = machine;
    expected = model_fault(addr, instr, write, machine);
    @(negedge clock);
    check_value("result_valid", 32'd1, 32'(result_valid));
    check_value($sformatf("fault @%h i%0b w%0b m%0b", addr, instr, write, machine),
                32'(expected), 32'(access_fault));
    access_valid = 1'b0;
  endtask

  task automatic test_reset_defaults();
    test_name = "reset_defaults";
    for (int n = 0; n < pmp_pkg::cfg_word_count; n++) begin
      axi_read_check(8'(4 * n), 32'd0, pmp_pkg::resp_okay);
    end
    for (int i = 0; i < pmp_pkg::region_count; i++) begin
      axi_read_check(8'(8'h40 + 4 * i), 32'd0, pmp_pkg::resp_okay);
    end
    check_access(32'h0000_1000, 1'b0, 1'b0, 1'b1);
    check_access(32'h0000_1000, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic test_register_access();
    test_name = "register_access";
    axi_write(8'h04, 32'h6765_6361, 4'hF);
    axi_read_check(8'h04, 32'h0705_0301, pmp_pkg::resp_okay);
    axi_write(8'h04, 32'h0000_1B00, 4'b0010);
    axi_read_check(8'h04, 32'h0705_1B01, pmp_pkg::resp_okay);
    axi_write(8'h4C, 32'h1234_5678, 4'hF);
    axi_write(8'h4C, 32'hABCD_EF01, 4'b1000);
    axi_read_check(8'h4C, 32'hAB34_5678, pmp_pkg::resp_okay);
    axi_write(8'h80, 32'hFFFF_FFFF, 4'hF);
    axi_read_check(8'h80, 32'd0, pmp_pkg::resp_slverr);
    axi_write(8'h04, 32'd0, 4'hF);
    axi_write(8'h4C, 32'd0, 4'hF);
  endtask

  task automatic test_address_modes();
    logic [31:0] points [12];
    points = '{32'h0FFC, 32'h1000, 32'h1003, 32'h1004, 32'h1FFC, 32'h2000,
               32'h201C, 32'h2020, 32'h2FFC, 32'h3000, 32'h303C, 32'h3040};
    test_name = "address_modes";
    // NA4 at 0x1000, NAPOT 0x2000..0x201F, TOR 0x3000..0x303F
    axi_write(8'h40, 32'h0000_0400, 4'hF);
    axi_write(8'h44, 32'h0000_0803, 4'hF);
    axi_write(8'h48, 32'h0000_0C00, 4'hF);
    axi_write(8'h4C, 32'h0000_0C10, 4'hF);
    axi_write(8'h00, 32'h0C00_1B11, 4'hF);
    foreach (points[p]) begin
      check_access(points[p], 1'b0, 1'b0, 1'b0);
      check_access(points[p], 1'b0, 1'b1, 1'b0);
      check_access(points[p], 1'b1, 1'b0, 1'b0);
    end
  endtask

  task automatic test_priority();
    test_name = "priority";
    // Region 4 denies 0x4000..0x5FFF inside region 5 which allows 0..0xFFFF
    axi_write(8'h50, 32'h0000_13FF, 4'hF);
    axi_write(8'h54, 32'h0000_1FFF, 4'hF);
    axi_write(8'h04, 32'h0000_1F18, 4'hF);
    check_access(32'h0000_4100, 1'b0, 1'b0, 1'b0);
    check_access(32'h0000_5FFC, 1'b0, 1'b1, 1'b0);
    check_access(32'h0000_4100, 1'b1, 1'b0, 1'b1);
    check_access(32'h0000_8000, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic test_locking();
    test_name = "locking";
    axi_write(8'h58, 32'h0000_4000, 4'hF);
    axi_write(8'h5C, 32'h0000_4040, 4'hF);
    axi_write(8'h04, 32'h8900_0000, 4'b1000);
    axi_write(8'h04, 32'h1F00_0000, 4'b1000);
    axi_write(8'h5C, 32'h0000_5555, 4'hF);
    axi_write(8'h58, 32'h0000_6666, 4'hF);
    axi_read_check(8'h04, 32'h8900_1F18, pmp_pkg::resp_okay);
    axi_read_check(8'h58, 32'h0000_4000, pmp_pkg::resp_okay);
    axi_read_check(8'h5C, 32'h0000_4040, pmp_pkg::resp_okay);
    check_access(32'h0001_0000, 1'b0, 1'b1, 1'b1);
    check_access(32'h0001_0080, 1'b0, 1'b0, 1'b1);
    check_access(32'h0001_0080, 1'b1, 1'b0, 1'b1);
    check_access(32'h0001_0100, 1'b0, 1'b0, 1'b1);
  endtask

  task automatic test_random_stream();
    logic [31:0] rnd;
    logic [31:0] addr;
    logic expected;
    logic pending;
    test_name = "random_stream";
    for (int i = 0; i < pmp_pkg::region_count; i++) begin
      rnd = $urandom;
      axi_write(8'(8'h40 + 4 * i), rnd & 32'h0000_0FFF, 4'hF);
    end
    for (int n = 0; n < pmp_pkg::cfg_word_count; n++) begin
      axi_write(8'(4 * n), $urandom, 4'hF);
    end
    pending = 1'b0;
    for (int n = 0; n <= 200; n++) begin
      @(negedge clock);
      if (pending) begin
        check_value("stream result_valid", 32'd1, 32'(result_valid));
        check_value($sformatf("stream fault @%h", addr), 32'(expected), 32'(access_fault));
      end
      if (n < 200) begin
        rnd = $urandom;
        addr = $urandom & 32'h0000_3FFF;
        access_valid = 1'b1;
        access_addr = addr;
        access_instr = rnd[0];
        access_write = rnd[1];
        access_machine = rnd[2];
        expected = model_fault(addr, rnd[0], rnd[1], rnd[2]);
        pending = 1'b1;
      end else begin
        access_valid = 1'b0;
      end
    end
  endtask

  initial begin
    void'($urandom(32'h67386477));
    reset = 1'b1;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    access_valid = 1'b0;
    access_addr = '0;
    access_instr = 1'b0;
    access_write = 1'b0;
    access_machine = 1'b0;
    test_name = "setup";
    for (int i = 0; i < pmp_pkg::region_count; i++) begin
      cfg_model[i] = 8'd0;
      addr_model[i] = 32'd0;
    end
    repeat (8) @(negedge clock);
    reset = 1'b0;
    test_reset_defaults();
    test_register_access();
    test_address_modes();
    test_priority();
    test_locking();
    test_random_stream();
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- verilog.f
rtl/pmp_pkg.sv
rtl/pmp_csr_axil.sv
rtl/pmp_region_match.sv
rtl/pmp_priority_resolve.sv
rtl/pmp_checker.sv
tb/pmp_checker_tb.sv
